// File: run_sim.sh
#!/usr/bin/env bash
# compile with verilator and run the testbench.
set -e
set -o pipefail
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
  --top-module cgra_acc_tb -f src.f
./obj_dir/Vcgra_acc_tb | tee sim.log
if grep -q "TEST FAILED" sim.log; then
  exit 1
fi
if ! grep -q "TEST PASSED" sim.log; then
  exit 1
fi

// File: source/acc_pkg.sv
package acc_pkg;

  // memory channels seen by the accelerator.
  localparam int n_ch = 2;
  localparam int word_w = 64;         // one memory word.
  localparam int sample_w = 16;       // one stream sample.
  localparam int lanes_per_word = word_w / sample_w;

  // counter wide enough for 0 .. lanes_per_word.
  localparam int lane_cnt_w = $clog2(lanes_per_word + 1);

  // configuration reader.
  typedef enum logic [1:0] {
    cs_idle,
    cs_req_word,
    cs_wait_word,
    cs_done
  } conf_state_t;

  // execution sequencer.
  typedef enum logic [1:0] {
    es_idle,
    es_run,
    es_drain,
    es_done
  } exec_state_t;

endpackage

// File: source/cgra_acc.sv
module cgra_acc (
  input  logic                                     clk,
  input  logic                                     arst_n,
  input  logic                                     start,
  input  logic [acc_pkg::n_ch-1:0]                 available_read,
  input  logic [acc_pkg::n_ch-1:0]                 read_data_valid,
  input  logic [acc_pkg::n_ch-1:0]                 available_write,
  input  logic [acc_pkg::n_ch-1:0]                 done_rd_data,
  input  logic [acc_pkg::n_ch-1:0]                 done_wr_data,
  input  logic [acc_pkg::n_ch*acc_pkg::word_w-1:0] read_data,
  output logic [acc_pkg::n_ch-1:0]                 request_read,
  output logic [acc_pkg::n_ch-1:0]                 request_write,
  output logic [acc_pkg::n_ch*acc_pkg::word_w-1:0] write_data,
  output logic                                     done
);
  import acc_pkg::*;
  import cgra_pkg::*;

  logic                         conf_req;
  logic                         conf_done;
  logic [n_pe*pe_conf_w-1:0]    pe_conf;
  logic [n_ch-1:0]              read_mask;
  logic [n_ch-1:0]              write_mask;
  logic [n_ch-1:0]              en_fetch;
  logic                         en_array;
  logic [n_ch-1:0]              fetch_req;
  logic [n_ch-1:0]              fetch_valid;
  logic [n_ch-1:0]              fetch_ready;
  logic [n_ch*sample_w-1:0]     fetch_data_w;
  logic [n_ch-1:0]              fetch_empty;
  logic [n_ch-1:0]              arr_valid;
  logic [n_ch-1:0]              arr_ready;
  logic [n_ch*sample_w-1:0]     arr_data;
  logic                         array_empty;
  logic [n_ch-1:0]              dispatch_empty;

  // config reads share channel 0, fetch stays off until they end.
  assign request_read = fetch_req | {{(n_ch-1){1'b0}}, conf_req};

  control_conf control_conf (
    .clk(clk), .arst_n(arst_n), .start(start),
    .available_read(available_read[0]), .rd_data_valid(read_data_valid[0]),
    .rd_data(read_data[word_w-1:0]), .req_rd_data(conf_req), .pe_conf(pe_conf),
    .read_mask(read_mask), .write_mask(write_mask), .conf_done(conf_done)
  );

  control_exec control_exec (
    .clk(clk), .arst_n(arst_n), .start(start), .conf_done(conf_done),
    .read_mask(read_mask), .write_mask(write_mask),
    .done_rd(done_rd_data), .done_wr(done_wr_data),
    .fetch_empty(fetch_empty), .dispatch_empty(dispatch_empty),
    .array_empty(array_empty), .en_fetch(en_fetch), .en_array(en_array), .done(done)
  );

  cgra_array cgra (
    .clk(clk), .arst_n(arst_n), .en(en_array), .pe_conf(pe_conf),
    .in_valid(fetch_valid), .in_ready(fetch_ready), .in_data(fetch_data_w),
    .out_valid(arr_valid), .out_ready(arr_ready), .out_data(arr_data),
    .empty(array_empty)
  );

  for (genvar c = 0; c < n_ch; c++) begin : g_ch
    fetch_data fetch (
      .clk(clk), .arst_n(arst_n), .en(en_fetch[c]),
      .available_read(available_read[c]), .data_valid(read_data_valid[c]),
      .read_data(read_data[c*word_w +: word_w]), .request_read(fetch_req[c]),
      .out_valid(fetch_valid[c]), .out_ready(fetch_ready[c]),
      .out_data(fetch_data_w[c*sample_w +: sample_w]), .empty(fetch_empty[c])
    );

    dispatch_data dispatch (
      .clk(clk), .arst_n(arst_n), .in_valid(arr_valid[c]), .in_ready(arr_ready[c]),
      .in_data(arr_data[c*sample_w +: sample_w]),
      .available_write(available_write[c]), .request_write(request_write[c]),
      .write_data(write_data[c*word_w +: word_w]), .empty(dispatch_empty[c])
    );
  end

endmodule

// File: source/cgra_array.sv
module cgra_array (
  input  logic                                          clk,
  input  logic                                          arst_n,
  input  logic                                          en,
  input  logic [cgra_pkg::n_pe*cgra_pkg::pe_conf_w-1:0] pe_conf,
  input  logic [acc_pkg::n_ch-1:0]                      in_valid,
  output logic [acc_pkg::n_ch-1:0]                      in_ready,
  input  logic [acc_pkg::n_ch*acc_pkg::sample_w-1:0]    in_data,
  output logic [acc_pkg::n_ch-1:0]                      out_valid,
  input  logic [acc_pkg::n_ch-1:0]                      out_ready,
  output logic [acc_pkg::n_ch*acc_pkg::sample_w-1:0]    out_data,
  output logic                                          empty
);
  import acc_pkg::*;
  import cgra_pkg::*;

  logic [n_lanes*pe_per_lane-1:0] busy;

  function automatic logic [sample_w-1:0] pe_calc(pe_op_t op, logic [pe_const_w-1:0] cst,
                                                  logic [sample_w-1:0] x);
    logic [sample_w-1:0] c;
    c = sample_w'(cst);
    case (op)
      op_add:  return x + c;
      op_sub:  return x - c;
      op_mul:  return x * c;
      default: return x;
    endcase
  endfunction

  for (genvar l = 0; l < n_lanes; l++) begin : g_lane
    logic [pe_per_lane:0] v_c;         // v_c[s] feeds stage s.
    logic [pe_per_lane:0] r_c;         // r_c[s] is stage s able to load.
    logic [sample_w-1:0]  d_c [pe_per_lane+1];

    assign v_c[0] = in_valid[l] & en;
    assign d_c[0] = in_data[l*sample_w +: sample_w];
    assign r_c[pe_per_lane] = out_ready[l];

    for (genvar s = 0; s < pe_per_lane; s++) begin : g_stage
      localparam int k = l*pe_per_lane + s;
      pe_op_t              op;
      logic [pe_const_w-1:0] cst;
      logic                vld_q;
      logic [sample_w-1:0] dat_q;

      assign op = pe_op_t'(pe_conf[k*pe_conf_w + pe_op_lsb +: pe_op_w]);
      assign cst = pe_conf[k*pe_conf_w +: pe_const_w];
      assign r_c[s] = ~vld_q | r_c[s+1];   // free, or emptying this cycle.
      assign v_c[s+1] = vld_q;
      assign d_c[s+1] = dat_q;
      assign busy[k] = vld_q;

      always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
          vld_q <= 1'b0;
        end else if (r_c[s]) begin
          vld_q <= v_c[s];
        end
      end

      always_ff @(posedge clk) begin
        if (r_c[s] && v_c[s]) begin
          dat_q <= pe_calc(op, cst, d_c[s]);
        end
      end
    end

    assign in_ready[l] = en & r_c[0];
    assign out_valid[l] = v_c[pe_per_lane];
    assign out_data[l*sample_w +: sample_w] = d_c[pe_per_lane];
  end

  assign empty = ~|busy;

endmodule

// File: source/cgra_pkg.sv
package cgra_pkg;

  // array geometry.
  localparam int pe_per_lane = 2;
  localparam int n_pe = 4;
  localparam int n_lanes = n_pe / pe_per_lane;

  // per-PE field of configuration word 0.
  localparam int pe_conf_w = 16;
  localparam int pe_const_w = 14;     // unsigned, zero extended.
  localparam int pe_op_w = 2;
  localparam int pe_op_lsb = pe_const_w;

  // mask fields of configuration word 1.
  localparam int rd_mask_lsb = 0;
  localparam int wr_mask_lsb = 2;

  // all results wrap modulo 2^16.
  typedef enum logic [pe_op_w-1:0] {
    op_pass,
    op_add,
    op_sub,
    op_mul
  } pe_op_t;

endpackage

// File: source/control_conf.sv
module control_conf (
  input  logic                                         clk,
  input  logic                                         arst_n,
  input  logic                                         start,
  input  logic                                         available_read,
  input  logic                                         rd_data_valid,
  input  logic [acc_pkg::word_w-1:0]                   rd_data,
  output logic                                         req_rd_data,
  output logic [cgra_pkg::n_pe*cgra_pkg::pe_conf_w-1:0] pe_conf,
  output logic [acc_pkg::n_ch-1:0]                     read_mask,
  output logic [acc_pkg::n_ch-1:0]                     write_mask,
  output logic                                         conf_done
);
  import acc_pkg::*;
  import cgra_pkg::*;

  conf_state_t       state_q;
  logic              second_q;   // working on the mask word.
  logic              got_q;      // reply seen last cycle.
  logic [word_w-1:0] data_q;

  assign req_rd_data = (state_q == cs_req_word) & available_read;
  assign conf_done = (state_q == cs_done);

  always_ff @(posedge clk) begin
    data_q <= rd_data;
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state_q <= cs_idle;
      second_q <= 1'b0;
      got_q <= 1'b0;
      pe_conf <= '0;
      read_mask <= '0;
      write_mask <= '0;
    end else begin
      got_q <= rd_data_valid & (state_q == cs_wait_word);
      case (state_q)
        cs_idle: begin
          if (start) begin
            state_q <= cs_req_word;
            second_q <= 1'b0;
          end
        end
        cs_req_word: begin
          if (available_read) begin
            state_q <= cs_wait_word;
          end
        end
        cs_wait_word: begin
          if (got_q) begin
            if (second_q) begin
              read_mask <= data_q[rd_mask_lsb +: n_ch];
              write_mask <= data_q[wr_mask_lsb +: n_ch];
              state_q <= cs_done;
            end else begin
              pe_conf <= data_q[n_pe*pe_conf_w-1:0];
              second_q <= 1'b1;
              state_q <= cs_req_word;
            end
          end
        end
        default: state_q <= cs_idle;   // cs_done lasts one cycle.
      endcase
    end
  end

endmodule

// File: source/control_exec.sv
module control_exec (
  input  logic                     clk,
  input  logic                     arst_n,
  input  logic                     start,
  input  logic                     conf_done,
  input  logic [acc_pkg::n_ch-1:0] read_mask,
  input  logic [acc_pkg::n_ch-1:0] write_mask,
  input  logic [acc_pkg::n_ch-1:0] done_rd,
  input  logic [acc_pkg::n_ch-1:0] done_wr,
  input  logic [acc_pkg::n_ch-1:0] fetch_empty,
  input  logic [acc_pkg::n_ch-1:0] dispatch_empty,
  input  logic                     array_empty,
  output logic [acc_pkg::n_ch-1:0] en_fetch,
  output logic                     en_array,
  output logic                     done
);
  import acc_pkg::*;

  exec_state_t state_q;
  logic        rd_all;
  logic        wr_all;
  logic        drained;

  // disabled channels count as finished.
  assign rd_all = &(done_rd | ~read_mask);
  assign wr_all = &(done_wr | ~write_mask);
  assign drained = (&fetch_empty) & (&dispatch_empty) & array_empty;

  assign en_array = (state_q == es_run) | (state_q == es_drain);
  assign en_fetch = en_array ? read_mask : '0;
  assign done = (state_q == es_done);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state_q <= es_idle;
    end else if (start) begin
      state_q <= es_idle;            // new run, clears done.
    end else begin
      case (state_q)
        es_idle: begin
          if (conf_done) begin
            state_q <= es_run;
          end
        end
        es_run: begin
          if (rd_all) begin
            state_q <= es_drain;
          end
        end
        es_drain: begin
          if (wr_all && drained) begin
            state_q <= es_done;
          end
        end
        default: state_q <= es_done;
      endcase
    end
  end

endmodule

// File: source/dispatch_data.sv
module dispatch_data (
  input  logic                         clk,
  input  logic                         arst_n,
  input  logic                         in_valid,
  output logic                         in_ready,
  input  logic [acc_pkg::sample_w-1:0] in_data,
  input  logic                         available_write,
  output logic                         request_write,
  output logic [acc_pkg::word_w-1:0]   write_data,
  output logic                         empty
);
  import acc_pkg::*;

  logic [word_w-1:0]     word_q;
  logic [lane_cnt_w-1:0] fill_q;    // lanes collected so far.
  logic                  full;
  logic                  push;

  assign full = (fill_q == lane_cnt_w'(lanes_per_word));
  assign push = in_valid & in_ready;

  // hold the full word until the host can take it.
  assign in_ready = ~full;
  assign request_write = full & available_write;
  assign write_data = word_q;
  assign empty = (fill_q == '0);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      fill_q <= '0;
    end else if (request_write) begin
      fill_q <= '0;                  // word handed over.
    end else if (push) begin
      fill_q <= fill_q + 1'b1;
    end
  end

  // shifting in from the top leaves the first sample in the lowest lane.
  always_ff @(posedge clk) begin
    if (push) begin
      word_q <= {in_data, word_q[word_w-1:sample_w]};
    end
  end

endmodule

// File: source/fetch_data.sv
module fetch_data (
  input  logic                         clk,
  input  logic                         arst_n,
  input  logic                         en,
  input  logic                         available_read,
  input  logic                         data_valid,
  input  logic [acc_pkg::word_w-1:0]   read_data,
  output logic                         request_read,
  output logic                         out_valid,
  input  logic                         out_ready,
  output logic [acc_pkg::sample_w-1:0] out_data,
  output logic                         empty
);
  import acc_pkg::*;

  logic [word_w-1:0]     buf_q;
  logic [lane_cnt_w-1:0] left_q;    // lanes still to pop.
  logic                  pend_q;    // one read outstanding.
  logic                  take;
  logic                  pop;

  // channel 0 also answers the config reader, so only our own reply counts.
  assign take = pend_q & data_valid;
  assign pop = out_valid & out_ready;

  assign request_read = en & available_read & ~pend_q & (left_q == '0);
  assign out_valid = (left_q != '0);
  assign out_data = buf_q[sample_w-1:0];   // lowest lane goes first.
  assign empty = ~pend_q & (left_q == '0);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pend_q <= 1'b0;
      left_q <= '0;
    end else begin
      if (request_read) begin
        pend_q <= 1'b1;
      end else if (take) begin
        pend_q <= 1'b0;
      end
      if (take) begin
        left_q <= lane_cnt_w'(lanes_per_word);
      end else if (pop) begin
        left_q <= left_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      buf_q <= read_data;
    end else if (pop) begin
      buf_q <= buf_q >> sample_w;
    end
  end

endmodule

// File: src.f
source/acc_pkg.sv
source/cgra_pkg.sv
source/fetch_data.sv
source/dispatch_data.sv
source/control_conf.sv
source/control_exec.sv
source/cgra_array.sv
source/cgra_acc.sv
tb/cgra_acc_assert.sv
tb/cgra_acc_tb.sv

// File: tb/cgra_acc_assert.sv
module cgra_acc_assert (
  input logic                     clk,
  input logic                     arst_n,
  input logic                     start,
  input logic [acc_pkg::n_ch-1:0] available_read,
  input logic [acc_pkg::n_ch-1:0] request_read,
  input logic [acc_pkg::n_ch-1:0] available_write,
  input logic [acc_pkg::n_ch-1:0] request_write,
  input logic                     done
);
  timeunit 1ns;
  timeprecision 1ps;

  rd_allowed: assert property (@(posedge clk) disable iff (!arst_n)
    (request_read & ~available_read) == '0)
    else $error("request_read raised while available_read is low");

  wr_allowed: assert property (@(posedge clk) disable iff (!arst_n)
    (request_write & ~available_write) == '0)
    else $error("request_write raised while available_write is low");

  // a new start clears done at once.
  done_cleared: assert property (@(posedge clk) disable iff (!arst_n) start |=> !done)
    else $error("done high in the cycle after start");

endmodule

bind cgra_acc cgra_acc_assert protocol_check (
  .clk(clk), .arst_n(arst_n), .start(start),
  .available_read(available_read), .request_read(request_read),
  .available_write(available_write), .request_write(request_write), .done(done)
);

// File: tb/cgra_acc_tb.sv
module cgra_acc_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import acc_pkg::*;
  import cgra_pkg::*;

  // config words plus data words, summed over all five runs.
  localparam int total_words = (2 + 16) * 3 + (2 + 8) + (2 + 12);
  localparam int cycle_limit = 200 * total_words;
  localparam logic [31:0] seed = 32'h17309ea0;

  logic                   clk = 1'b0;
  logic                   arst_n;
  logic                   start;
  logic [n_ch-1:0]        available_read;
  logic [n_ch-1:0]        read_data_valid;
  logic [n_ch-1:0]        available_write;
  logic [n_ch-1:0]        done_rd_data;
  logic [n_ch-1:0]        done_wr_data;
  logic [n_ch*word_w-1:0] read_data;
  logic [n_ch-1:0]        request_read;
  logic [n_ch-1:0]        request_write;
  logic [n_ch*word_w-1:0] write_data;
  logic                   done;

  logic [word_w-1:0] rd_q [n_ch][$];    // words the host still hands out.
  logic [word_w-1:0] exp_q [n_ch][$];   // words the host still expects.
  logic [word_w-1:0] pend_w [n_ch];
  int                lat [n_ch];
  logic [n_ch-1:0]   req_hit;
  logic [31:0]       data_rng = seed;
  logic [31:0]       host_rng = seed;
  logic              bp = 1'b0;
  logic              ch1_quiet = 1'b0;
  logic              running = 1'b0;
  int                cycles = 0;
  int                errors = 0;
  int                tests = 0;
  int                fails = 0;

  cgra_acc UUT (.*);

  always #5 clk = ~clk;

  function automatic logic [31:0] lcg_next(logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [word_w-1:0] rand_word();
    logic [31:0] hi;
    data_rng = lcg_next(data_rng);
    hi = data_rng;
    data_rng = lcg_next(data_rng);
    return {hi, data_rng};
  endfunction

  // exact result first, then reduced modulo 2^16.
  function automatic logic [15:0] apply_op(pe_op_t op, logic [13:0] k, logic [15:0] x);
    int exact;
    case (op)
      op_add:  exact = int'(x) + int'(k);
      op_sub:  exact = 65536 + int'(x) - int'(k);
      op_mul:  exact = int'(x) * int'(k);
      default: exact = int'(x);
    endcase
    return 16'(exact % 65536);
  endfunction

  // two stages of one lane, everything wraps at 16 bits.
  function automatic logic [15:0] pe_model(pe_op_t op0, logic [13:0] k0, pe_op_t op1,
                                           logic [13:0] k1, logic [15:0] x);
    return apply_op(op1, k1, apply_op(op0, k0, x));
  endfunction

  function automatic logic [word_w-1:0] expect_word(logic [word_w-1:0] conf, int lane,
                                                    logic [word_w-1:0] w);
    logic [word_w-1:0] r;
    logic [15:0]       s0;
    logic [15:0]       s1;
    s0 = conf[32*lane +: 16];      // stage 0 is the lower PE.
    s1 = conf[32*lane+16 +: 16];
    for (int j = 0; j < lanes_per_word; j++) begin
      r[16*j +: 16] = pe_model(pe_op_t'(s0[15:14]), s0[13:0], pe_op_t'(s1[15:14]), s1[13:0],
                               w[16*j +: 16]);
    end
    return r;
  endfunction

  function automatic logic [15:0] pe_field(pe_op_t op, logic [13:0] k);
    return {op, k};
  endfunction

  task automatic check_word(input string name, input logic [word_w-1:0] got,
                            input logic [word_w-1:0] exp);
    if (got !== exp) begin
      $display("** Error: %s got %h exp %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_done(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("** Error: %s got %h exp %h", name, got, exp);
      errors++;
    end
  endtask

  // requests and writes are taken on the rising edge.
  always @(posedge clk) begin
    logic [word_w-1:0] w;
    cycles++;
    for (int c = 0; c < n_ch; c++) begin
      if (request_read[c]) req_hit[c] = 1'b1;
      if (request_write[c]) begin
        if (exp_q[c].size() == 0) begin
          $display("channel %0d wrote a word that was not expected", c);
          errors++;
        end else begin
          w = exp_q[c].pop_front();
          check_word($sformatf("write_data[%0d]", c), write_data[c*word_w +: word_w], w);
        end
      end
    end
    if (ch1_quiet && (request_read[1] || request_write[1])) begin
      $display("channel 1 is masked off but made a request");
      errors++;
    end
    if (running && done && !((&done_rd_data) && (&done_wr_data))) begin
      check_done("done", done, 1'b0);
    end
  end

  // host side, driven on the falling edge.
  always @(negedge clk) begin
    for (int c = 0; c < n_ch; c++) begin
      read_data_valid[c] = 1'b0;
      if (req_hit[c]) begin
        req_hit[c] = 1'b0;
        if (rd_q[c].size() == 0) begin
          $display("channel %0d asked for a word after the last one", c);
          errors++;
        end else begin
          pend_w[c] = rd_q[c].pop_front();
          host_rng = lcg_next(host_rng);
          lat[c] = 1 + int'(host_rng[29:28]);   // 1 to 4 cycles.
        end
      end else if (lat[c] > 0) begin
        lat[c]--;
        if (lat[c] == 0) begin
          read_data_valid[c] = 1'b1;
          read_data[c*word_w +: word_w] = pend_w[c];
        end
      end
      // a masked channel is still offered reads, so only the mask keeps it quiet.
      available_read[c] = (rd_q[c].size() != 0) || (c == 1 && ch1_quiet);
      done_rd_data[c] = (rd_q[c].size() == 0) && (lat[c] == 0);
      host_rng = lcg_next(host_rng);
      available_write[c] = bp ? host_rng[20] : 1'b1;
      done_wr_data[c] = (exp_q[c].size() == 0);
    end
  end

  task automatic run_test(input string name, input logic [word_w-1:0] conf0,
                          input logic [n_ch-1:0] mask, input int nwords, input logic stall);
    int                err_before;
    logic [word_w-1:0] w;
    err_before = errors;
    @(negedge clk);
    for (int c = 0; c < n_ch; c++) begin
      if (mask[c]) begin
        for (int i = 0; i < nwords; i++) begin
          w = rand_word();
          rd_q[c].push_back(w);
          exp_q[c].push_back(expect_word(conf0, c, w));
        end
      end
    end
    rd_q[0].push_front({60'd0, mask, mask});   // write mask follows the read mask.
    rd_q[0].push_front(conf0);
    bp = stall;
    ch1_quiet = ~mask[1];
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
    check_done("done", done, 1'b0);
    running = 1'b1;
    while (done !== 1'b1) @(negedge clk);
    running = 1'b0;
    if (exp_q[0].size() != 0 || exp_q[1].size() != 0) begin
      $display("done rose with words still missing");
      errors++;
    end
    repeat (4) begin
      @(negedge clk);
      check_done("done", done, 1'b1);
    end
    bp = 1'b0;
    ch1_quiet = 1'b0;
    tests++;
    if (errors == err_before) begin
      $display("test %s: ok", name);
    end else begin
      fails++;
      $display("test %s: failed", name);
    end
  endtask

  initial begin
    arst_n = 1'b0;
    start = 1'b0;
    available_read = '0;
    read_data_valid = '0;
    available_write = '0;
    done_rd_data = '0;
    done_wr_data = '0;
    read_data = '0;
    req_hit = '0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    run_test("add_sub_mul_pass", {pe_field(op_pass, 14'd0), pe_field(op_mul, 14'd3),
             pe_field(op_sub, 14'd7), pe_field(op_add, 14'd100)}, 2'b11, 8, 1'b0);
    run_test("all_ops", {pe_field(op_add, 14'h3fff), pe_field(op_pass, 14'h3fff),
             pe_field(op_sub, 14'd0), pe_field(op_mul, 14'h3fff)}, 2'b11, 8, 1'b0);
    run_test("back_pressure", {pe_field(op_pass, 14'd0), pe_field(op_mul, 14'd3),
             pe_field(op_sub, 14'd7), pe_field(op_add, 14'd100)}, 2'b11, 8, 1'b1);
    run_test("mask_01", {pe_field(op_pass, 14'd0), pe_field(op_pass, 14'd0),
             pe_field(op_add, 14'd1), pe_field(op_sub, 14'h3fff)}, 2'b01, 8, 1'b0);
    check_done("done", done, 1'b1);        // still held from the last run.
    run_test("restart", {pe_field(op_sub, 14'd2), pe_field(op_add, 14'd1),
             pe_field(op_mul, 14'h2001), pe_field(op_mul, 14'd5)}, 2'b11, 6, 1'b0);
    $display("%0d tests, %0d failed, %0d errors", tests, fails, errors);
    if (errors == 0 && fails == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin
    wait (cycles >= cycle_limit);
    $display("timeout, the run did not finish within %0d cycles", cycle_limit);
    $display("TEST FAILED");
    $finish;
  end

endmodule
